// ==== Bender.yml ====
package:
  name: lc3b_cpu

export_include_dirs:
  - source

sources:
  - source/lc3b_types.sv
  - source/alu.sv
  - source/regfile.sv
  - source/decode.sv
  - source/datapath.sv
  - source/mem_align.sv
  - source/cpu.sv
  - target: test
    files:
      - verification/cpu_checker.sv
      - verification/cpu_assertions.sv
      - verification/tb_cpu.sv

// ==== source/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu
    import lc3b_types::*;
(
    input  lc3b_aluop aluop,
    input  lc3b_word  a,
    input  lc3b_word  b,
    output lc3b_word  f
);

always_comb
begin
    case (aluop)
        alu_add:
            f = a + b;
        alu_and:
            f = a & b;
        alu_not:
            f = ~a;
        default:
            f = a;          // alu_pass, b ignored
    endcase
end

endmodule : alu

`default_nettype wire

// ==== source/cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu
    import lc3b_types::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          i_resp,
    input  lc3b_word      i_rdata,
    input  logic          d_resp,
    input  lc3b_word      d_rdata,
    output lc3b_word      i_addr,
    output logic          i_read,
    output lc3b_word      d_addr,
    output logic          d_read,
    output logic          d_write,
    output lc3b_mem_wmask d_byte_enable,
    output lc3b_word      d_wdata
);

// memory stage request, before byte steering
lc3b_word addr_mem;
lc3b_word wdata_mem;
logic     read_mem;
logic     write_mem;
logic     byte_mem;
lc3b_word mem_rdata;    // sign-extended already for ldb
logic     mem_resp;

datapath datapath0 (.*);

mem_align align0 (.*);

endmodule : cpu

`default_nettype wire

// ==== source/datapath.sv ====
`timescale 1ns/1ps
`include "lc3b_config.svh"
`default_nettype none

module datapath
    import lc3b_types::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     i_resp,
    input  lc3b_word i_rdata,
    input  logic     mem_resp,
    input  lc3b_word mem_rdata,
    output lc3b_word i_addr,
    output logic     i_read,
    output lc3b_word addr_mem,
    output lc3b_word wdata_mem,
    output logic     read_mem,
    output logic     write_mem,
    output logic     byte_mem
);

lc3b_word   pc;
lc3b_word   pc_plus2;
lc3b_word   ir_buf;             // fetched while the data port held the pipe
logic       buf_valid;
logic       i_gap;              // idle cycle after each fetch resp
logic       i_pending;
logic       stall_i;
logic       stall_d;
logic       advance;
lc3b_instr  ir_id;
lc3b_word   pc_id;
logic       sr2_sel_id;
logic       imm_sel_id;
logic       sh6_sel_id;
logic       alumux1_sel_id;
logic [1:0] alumux2_sel_id;
lc3b_aluop  aluop_id;
logic       read_id;
logic       write_id;
logic       byte_id;
logic       load_regfile_id;
logic       regfilemux_sel_id;
lc3b_reg    src_a_id;
lc3b_reg    src_b_id;
lc3b_word   sr1_id;
lc3b_word   sr2_id;
lc3b_word   opnd_a_id;
lc3b_word   opnd_b_id;
lc3b_word   opnd_a_ex;
lc3b_word   opnd_b_ex;
lc3b_word   sr2_ex;
lc3b_reg    dest_ex;
lc3b_aluop  aluop_ex;
logic       read_ex;
logic       write_ex;
logic       byte_ex;
logic       load_regfile_ex;
logic       regfilemux_sel_ex;
lc3b_word   alu_out;
lc3b_reg    dest_mem;
logic       load_regfile_mem;
logic       regfilemux_sel_mem;
lc3b_word   alu_wb;
lc3b_word   mem_wb;
lc3b_reg    dest_wb;
logic       load_regfile_wb;
logic       regfilemux_sel_wb;
lc3b_word   wb_data;

assign stall_d  = (read_mem | write_mem) & ~mem_resp;
assign stall_i  = ~i_resp & ~buf_valid;
assign advance  = ~stall_i & ~stall_d;
assign pc_plus2 = pc + lc3b_word'(2);
assign i_addr   = pc;
// once started, a fetch is held through a data stall
assign i_read   = ~i_gap & ~buf_valid & (~stall_d | i_pending);

decode dec0
(
    .instr          (ir_id),
    .sr2_sel        (sr2_sel_id),
    .imm_sel        (imm_sel_id),
    .sh6_sel        (sh6_sel_id),
    .alumux1_sel    (alumux1_sel_id),
    .alumux2_sel    (alumux2_sel_id),
    .aluop          (aluop_id),
    .read           (read_id),
    .write          (write_id),
    .byte_access    (byte_id),
    .load_regfile   (load_regfile_id),
    .regfilemux_sel (regfilemux_sel_id)
);

// sr1 and the memory base share one field of the union
assign src_a_id  = ir_id.op.sr1;
assign src_b_id  = sr2_sel_id ? ir_id.mem.dr : ir_id.op.imm5[2:0];
assign opnd_a_id = alumux1_sel_id ? pc_id : sr1_id;    // pc only for lea

regfile rf0
(
    .clk,
    .reset,
    .load  (load_regfile_wb),
    .in    (wb_data),
    .src_a (src_a_id),
    .src_b (src_b_id),
    .dest  (dest_wb),
    .reg_a (sr1_id),
    .reg_b (sr2_id)
);

always_comb
begin
    case (alumux2_sel_id)
        2'b00:
            opnd_b_id = sr2_id;
        2'b10:
            opnd_b_id = {{(`LC3B_WORD_W-10){ir_id.mem.base[2]}}, ir_id.mem.base,
                         ir_id.mem.offset6, 1'b0};    // offset9 times two
        default:
            if (!imm_sel_id)
                opnd_b_id = {{(`LC3B_WORD_W-5){ir_id.op.imm5[4]}}, ir_id.op.imm5};
            else if (sh6_sel_id)
                opnd_b_id = {{(`LC3B_WORD_W-7){ir_id.mem.offset6[5]}}, ir_id.mem.offset6, 1'b0};
            else
                opnd_b_id = {{(`LC3B_WORD_W-6){ir_id.mem.offset6[5]}}, ir_id.mem.offset6};
    endcase
end

alu alu0
(
    .aluop (aluop_ex),
    .a     (opnd_a_ex),
    .b     (opnd_b_ex),
    .f     (alu_out)
);

assign wb_data = regfilemux_sel_wb ? mem_wb : alu_wb;

always_ff @(posedge clk or posedge reset)
begin
    if (reset)
    begin
        pc               <= `LC3B_RESET_PC;
        i_gap            <= 1'b0;
        i_pending        <= 1'b0;
        buf_valid        <= 1'b0;
        ir_id            <= '0;
        read_ex          <= 1'b0;
        write_ex         <= 1'b0;
        load_regfile_ex  <= 1'b0;
        read_mem         <= 1'b0;
        write_mem        <= 1'b0;
        load_regfile_mem <= 1'b0;
        load_regfile_wb  <= 1'b0;
    end
    else
    begin
        i_gap     <= i_resp;
        i_pending <= i_read & ~i_resp;
        if (advance)
        begin
            pc        <= pc_plus2;
            ir_id     <= buf_valid ? ir_buf : i_rdata;
            buf_valid <= 1'b0;
        end
        else if (i_resp)
            buf_valid <= 1'b1;      // resp landed during a data stall
        if (!stall_d)
        begin
            if (stall_i)
                ir_id <= '0;        // br, so decode sees a bubble
            read_ex          <= read_id;
            write_ex         <= write_id;
            load_regfile_ex  <= load_regfile_id;
            read_mem         <= read_ex;
            write_mem        <= write_ex;
            load_regfile_mem <= load_regfile_ex;
            load_regfile_wb  <= load_regfile_mem;
        end
    end
end

always_ff @(posedge clk)
begin
    if (i_resp)
        ir_buf <= i_rdata;
    if (advance)
        pc_id <= pc_plus2;
    if (!stall_d)
    begin
        opnd_a_ex          <= opnd_a_id;
        opnd_b_ex          <= opnd_b_id;
        sr2_ex             <= sr2_id;
        dest_ex            <= ir_id.op.dr;
        aluop_ex           <= aluop_id;
        byte_ex            <= byte_id;
        regfilemux_sel_ex  <= regfilemux_sel_id;
        addr_mem           <= alu_out;     // doubles as the alu result
        wdata_mem          <= sr2_ex;
        byte_mem           <= byte_ex;
        dest_mem           <= dest_ex;
        regfilemux_sel_mem <= regfilemux_sel_ex;
        alu_wb             <= addr_mem;
        mem_wb             <= mem_rdata;
        dest_wb            <= dest_mem;
        regfilemux_sel_wb  <= regfilemux_sel_mem;
    end
end

endmodule : datapath

`default_nettype wire

// ==== source/decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode
    import lc3b_types::*;
(
    input  lc3b_instr  instr,
    output logic       sr2_sel,         // port b index from dr field
    output logic       imm_sel,         // offset6 instead of imm5
    output logic       sh6_sel,         // offset6 scaled by two
    output logic       alumux1_sel,     // pc as operand a
    output logic [1:0] alumux2_sel,     // 00 reg, 01 immediate, 10 offset9
    output lc3b_aluop  aluop,
    output logic       read,
    output logic       write,
    output logic       byte_access,
    output logic       load_regfile,
    output logic       regfilemux_sel   // load data instead of alu result
);

always_comb
begin
    // bubble unless the opcode is one we run
    sr2_sel        = 1'b0;
    imm_sel        = 1'b0;
    sh6_sel        = 1'b0;
    alumux1_sel    = 1'b0;
    alumux2_sel    = 2'b00;
    aluop          = alu_pass;
    read           = 1'b0;
    write          = 1'b0;
    byte_access    = 1'b0;
    load_regfile   = 1'b0;
    regfilemux_sel = 1'b0;

    case (instr.op.opcode)
        op_add, op_and:
        begin
            aluop        = (instr.op.opcode == op_add) ? alu_add : alu_and;
            alumux2_sel  = instr.op.imm_flag ? 2'b01 : 2'b00;
            load_regfile = 1'b1;
        end
        op_not:
        begin
            aluop        = alu_not;
            load_regfile = 1'b1;
        end
        op_lea:
        begin
            aluop        = alu_add;
            alumux1_sel  = 1'b1;
            alumux2_sel  = 2'b10;
            load_regfile = 1'b1;
        end
        // ldb 0010, stb 0011, ldr 0110, str 0111
        op_ldb, op_stb, op_ldr, op_str:
        begin
            aluop          = alu_add;
            imm_sel        = 1'b1;
            alumux2_sel    = 2'b01;
            sh6_sel        = instr.mem.opcode[2];   // word forms scale the offset
            byte_access    = ~instr.mem.opcode[2];
            sr2_sel        = instr.mem.opcode[0];   // store data
            write          = instr.mem.opcode[0];
            read           = ~instr.mem.opcode[0];
            load_regfile   = ~instr.mem.opcode[0];
            regfilemux_sel = 1'b1;
        end
        default: ;      // br and everything dropped
    endcase
end

endmodule : decode

`default_nettype wire

// ==== source/lc3b_config.svh ====
`ifndef LC3B_CONFIG_SVH
`define LC3B_CONFIG_SVH

// machine word, also the address width
`define LC3B_WORD_W 16

// r0..r7
`define LC3B_NUM_REGS 8

// first fetch address out of reset
`define LC3B_RESET_PC 16'h0000

`endif

// ==== source/lc3b_types.sv ====
`include "lc3b_config.svh"
`default_nettype none

package lc3b_types;

typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
typedef logic [$clog2(`LC3B_NUM_REGS)-1:0] lc3b_reg;
typedef logic [1:0] lc3b_mem_wmask;    // bit 1 high byte, bit 0 low byte

typedef enum logic [3:0] {
    op_br  = 4'b0000, op_add = 4'b0001, op_ldb = 4'b0010, op_stb  = 4'b0011,
    op_jsr = 4'b0100, op_and = 4'b0101, op_ldr = 4'b0110, op_str  = 4'b0111,
    op_rti = 4'b1000, op_not = 4'b1001, op_ldi = 4'b1010, op_sti  = 4'b1011,
    op_jmp = 4'b1100, op_shf = 4'b1101, op_lea = 4'b1110, op_trap = 4'b1111
} lc3b_opcode;

typedef enum logic [1:0] {
    alu_add,
    alu_and,
    alu_not,
    alu_pass
} lc3b_aluop;

// add, and, not
typedef struct packed {
    lc3b_opcode opcode;
    lc3b_reg    dr;
    lc3b_reg    sr1;
    logic       imm_flag;
    logic [4:0] imm5;      // sr2 in [2:0] when imm_flag is low
} lc3b_op_fields;

// ldr, str, ldb, stb; lea reads base and offset6 together as offset9
typedef struct packed {
    lc3b_opcode opcode;
    lc3b_reg    dr;        // source register for stores
    lc3b_reg    base;
    logic [5:0] offset6;
} lc3b_mem_fields;

typedef union packed {
    lc3b_op_fields  op;
    lc3b_mem_fields mem;
} lc3b_instr;

endpackage : lc3b_types

`default_nettype wire

// ==== source/mem_align.sv ====
`timescale 1ns/1ps
`include "lc3b_config.svh"
`default_nettype none

module mem_align
    import lc3b_types::*;
(
    input  lc3b_word      addr_mem,
    input  lc3b_word      wdata_mem,
    input  logic          read_mem,
    input  logic          write_mem,
    input  logic          byte_mem,
    input  logic          d_resp,
    input  lc3b_word      d_rdata,
    output lc3b_word      mem_rdata,
    output logic          mem_resp,
    output lc3b_word      d_addr,
    output logic          d_read,
    output logic          d_write,
    output lc3b_mem_wmask d_byte_enable,
    output lc3b_word      d_wdata
);

logic [7:0] rbyte;

assign d_addr   = {addr_mem[`LC3B_WORD_W-1:1], 1'b0};    // word aligned on the port
assign d_read   = read_mem;
assign d_write  = write_mem;
assign mem_resp = d_resp;

always_comb
begin
    if (!byte_mem)
        d_byte_enable = 2'b11;
    else if (addr_mem[0])
        d_byte_enable = 2'b10;      // odd address, high lane
    else
        d_byte_enable = 2'b01;
end

// store byte on both lanes, the enable picks one
assign d_wdata = byte_mem ? {2{wdata_mem[7:0]}} : wdata_mem;

assign rbyte     = addr_mem[0] ? d_rdata[15:8] : d_rdata[7:0];
assign mem_rdata = byte_mem ? {{(`LC3B_WORD_W-8){rbyte[7]}}, rbyte} : d_rdata;

endmodule : mem_align

`default_nettype wire

// ==== source/regfile.sv ====
`timescale 1ns/1ps
`include "lc3b_config.svh"
`default_nettype none

module regfile
    import lc3b_types::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     load,
    input  lc3b_word in,
    input  lc3b_reg  src_a,
    input  lc3b_reg  src_b,
    input  lc3b_reg  dest,
    output lc3b_word reg_a,
    output lc3b_word reg_b
);

lc3b_word regs [`LC3B_NUM_REGS];

always_ff @(posedge clk or posedge reset)
begin
    if (reset)
    begin
        for (int i = 0; i < `LC3B_NUM_REGS; i++)
            regs[i] <= '0;
    end
    else if (load)
        regs[dest] <= in;
end

// writeback value shows up on a read in the same cycle
assign reg_a = (load && dest == src_a) ? in : regs[src_a];
assign reg_b = (load && dest == src_b) ? in : regs[src_b];

endmodule : regfile

`default_nettype wire

// ==== src.f ====
+incdir+source
source/lc3b_types.sv
source/alu.sv
source/regfile.sv
source/decode.sv
source/datapath.sv
source/mem_align.sv
source/cpu.sv
verification/cpu_checker.sv
verification/cpu_assertions.sv
verification/tb_cpu.sv

// ==== verification/cpu_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_assertions
    import lc3b_types::*;
(
    input  logic          clk,
    input  logic          reset,
    input  lc3b_word      i_addr,
    input  logic          i_read,
    input  logic          i_resp,
    input  lc3b_word      d_addr,
    input  logic          d_read,
    input  logic          d_write,
    input  logic          d_resp,
    input  lc3b_mem_wmask d_byte_enable,
    input  lc3b_word      d_wdata
);

int fail_count = 0;     // failed assertion attempts so far

// fetch held until answered
assert property (@(posedge clk) disable iff (reset)
    (i_read && !i_resp) |=> (i_read && $stable(i_addr)))
    else
    begin
        $error("fetch request dropped or changed before i_resp");
        fail_count++;
    end

assert property (@(posedge clk) disable iff (reset)
    ((d_read || d_write) && !d_resp) |=>
        (d_read == $past(d_read) && d_write == $past(d_write) && $stable(d_addr)
         && $stable(d_wdata) && $stable(d_byte_enable)))
    else
    begin
        $error("data request dropped or changed before d_resp");
        fail_count++;
    end

assert property (@(posedge clk) !(d_read && d_write))
    else
    begin
        $error("d_read and d_write high together");
        fail_count++;
    end

assert property (@(posedge clk) reset |-> (!d_read && !d_write))
    else
    begin
        $error("data request active during reset");
        fail_count++;
    end

endmodule : cpu_assertions

bind cpu cpu_assertions asrt0
(
    .clk           (clk),
    .reset         (reset),
    .i_addr        (i_addr),
    .i_read        (i_read),
    .i_resp        (i_resp),
    .d_addr        (d_addr),
    .d_read        (d_read),
    .d_write       (d_write),
    .d_resp        (d_resp),
    .d_byte_enable (d_byte_enable),
    .d_wdata       (d_wdata)
);

`default_nettype wire

// ==== verification/cpu_checker.sv ====
`timescale 1ns/1ps
`include "lc3b_config.svh"
`default_nettype none

module cpu_checker
    import lc3b_types::*;
(
    input  logic          clk,
    input  logic          reset,
    input  lc3b_word      i_addr,
    input  logic          i_read,
    input  logic          i_resp,
    input  lc3b_word      d_addr,
    input  logic          d_write,
    input  logic          d_resp,
    input  lc3b_mem_wmask d_byte_enable,
    input  lc3b_word      d_wdata
);

lc3b_word      prog [1024];
lc3b_word      mem_model [int];     // only words the program touched
lc3b_word      exp_addr [$];
lc3b_mem_wmask exp_mask [$];
lc3b_word      exp_data [$];
lc3b_word      fetch_pc;
lc3b_word      want_addr;
lc3b_word      want_data;
lc3b_mem_wmask want_mask;
int            errors = 0;
int            writes_seen;
int            writes_expected;
int            fetches_seen;

// initial data memory contents, every address bit matters
function automatic lc3b_word fill_word(input int idx);
    lc3b_word a;
    a = {idx[14:0], 1'b0};
    return a ^ {a[7:0], a[15:8]} ^ 16'h3c5a;
endfunction

function automatic lc3b_word model_read(input lc3b_word ea);
    int idx;
    idx = int'(ea[15:1]);
    if (mem_model.exists(idx))
        return mem_model[idx];
    return fill_word(idx);
endfunction

task automatic load_instr(input int idx, input lc3b_word w);
    prog[idx] = w;
endtask

task automatic start_test();
    exp_addr.delete();
    exp_mask.delete();
    exp_data.delete();
    mem_model.delete();
    fetch_pc        = `LC3B_RESET_PC;
    writes_seen     = 0;
    writes_expected = 0;
    fetches_seen    = 0;
endtask

task automatic expect_store(input lc3b_word ea, input lc3b_mem_wmask mask,
                            input lc3b_word data);
    lc3b_word old;
    old = model_read(ea);
    mem_model[int'(ea[15:1])] = {mask[1] ? data[15:8] : old[15:8],
                                 mask[0] ? data[7:0] : old[7:0]};
    exp_addr.push_back({ea[15:1], 1'b0});
    exp_mask.push_back(mask);
    exp_data.push_back(data);
    writes_expected++;
endtask

// in-order ISA model over the first words of the program
task automatic run_model(input int words);
    lc3b_word   r [8];
    lc3b_word   pc;
    lc3b_word   ir;
    lc3b_word   ea;
    lc3b_word   w;
    logic [2:0] dr;
    for (int k = 0; k < 8; k++)
        r[k] = '0;
    pc = `LC3B_RESET_PC;
    while (int'(pc[15:1]) < words)
    begin
        ir = prog[pc[10:1]];
        pc = pc + 16'd2;
        dr = ir[11:9];
        case (ir[15:12])
            4'b0001, 4'b0101:
            begin
                w = ir[5] ? {{11{ir[4]}}, ir[4:0]} : r[ir[2:0]];
                r[dr] = (ir[15:12] == 4'b0001) ? r[ir[8:6]] + w : r[ir[8:6]] & w;
            end
            4'b1001:
                r[dr] = ~r[ir[8:6]];
            4'b1110:
                r[dr] = pc + {{6{ir[8]}}, ir[8:0], 1'b0};   // pc already past lea
            4'b0110:
            begin
                ea = r[ir[8:6]] + {{9{ir[5]}}, ir[5:0], 1'b0};
                r[dr] = model_read(ea);
            end
            4'b0111:
            begin
                ea = r[ir[8:6]] + {{9{ir[5]}}, ir[5:0], 1'b0};
                expect_store(ea, 2'b11, r[dr]);
            end
            4'b0010:
            begin
                ea = r[ir[8:6]] + {{10{ir[5]}}, ir[5:0]};
                w = model_read(ea);
                w = ea[0] ? {8'h00, w[15:8]} : w;
                r[dr] = {{8{w[7]}}, w[7:0]};
            end
            4'b0011:
            begin
                ea = r[ir[8:6]] + {{10{ir[5]}}, ir[5:0]};
                expect_store(ea, ea[0] ? 2'b10 : 2'b01, {2{r[dr][7:0]}});
            end
            default: ;  // nop
        endcase
    end
endtask

// all handshake signals settle well before the falling edge
always @(negedge clk)
begin
    if (!reset)
    begin
        if (i_read && i_resp)
        begin
            if (i_addr !== fetch_pc)
            begin
                errors++;
                $display("Mismatch at time %0t: fetch address expected %h, got %h",
                         $time, fetch_pc, i_addr);
            end
            fetch_pc = fetch_pc + 16'd2;
            fetches_seen++;
        end
        if (d_write && d_resp)
        begin
            if (exp_addr.size() == 0)
            begin
                errors++;
                $display("unexpected data write at time %0t to address %h after the last store",
                         $time, d_addr);
            end
            else
            begin
                want_addr = exp_addr.pop_front();
                want_mask = exp_mask.pop_front();
                want_data = exp_data.pop_front();
                if (d_addr !== want_addr || d_byte_enable !== want_mask ||
                    d_wdata !== want_data)
                begin
                    errors++;
                    $display("Mismatch at time %0t: store %0d expected %h/%b/%h, got %h/%b/%h",
                             $time, writes_seen, want_addr, want_mask, want_data,
                             d_addr, d_byte_enable, d_wdata);
                end
                writes_seen++;
            end
        end
    end
end

endmodule : cpu_checker

`default_nettype wire

// ==== verification/tb_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu
    import lc3b_types::*;
();

localparam int NUM_TESTS   = 3;
localparam int INSTRS      = 30;
localparam int PROG_WORDS  = INSTRS * 5 + 8;     // each op plus four nops, then the dump
localparam int WATCHDOG_NS = NUM_TESTS * PROG_WORDS * 6 * 40 * 5;

logic          clk;
logic          reset;
logic          i_resp;
lc3b_word      i_rdata;
logic          d_resp;
lc3b_word      d_rdata;
lc3b_word      i_addr;
logic          i_read;
lc3b_word      d_addr;
logic          d_read;
logic          d_write;
lc3b_mem_wmask d_byte_enable;
lc3b_word      d_wdata;
lc3b_word      imem [1024];
lc3b_word      dmem [32768];
integer        seed = 17;
int            i_wait;
int            d_wait;
int            failed;

cpu dut0 (.*);

cpu_checker chk0 (.*);

function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
endfunction

function automatic string test_name(input int t);
    case (t)
        0:       return "alu and lea";
        1:       return "word load/store";
        default: return "byte load/store";
    endcase
endfunction

task automatic put_word(inout int n, input lc3b_word w);
    imem[n] = w;
    chk0.load_instr(n, w);
    n++;
endtask

// r7 is never a destination, so it stays zero as the dump base
task automatic gen_program(input int mode, output int n);
    int         k;
    lc3b_word   w;
    logic [2:0] dr;
    logic [2:0] sr;
    logic [2:0] base;
    n = 0;
    for (int i = 0; i < INSTRS; i++)
    begin
        dr   = 3'(rand_below(7));
        sr   = 3'(rand_below(8));
        base = 3'(rand_below(8));
        k    = (mode == 0) ? rand_below(6) : rand_below(10);
        case (k)
            0: w = {4'b0001, dr, sr, 3'b000, base};
            1: w = {4'b0001, dr, sr, 1'b1, 5'(rand_below(32))};
            2: w = {4'b0101, dr, sr, 3'b000, base};
            3: w = {4'b0101, dr, sr, 1'b1, 5'(rand_below(32))};
            4: w = {4'b1001, dr, sr, 6'h3f};
            5: w = {4'b1110, dr, 9'(rand_below(512))};
            6, 7: w = {(mode == 1) ? 4'b0110 : 4'b0010, dr, base, 6'(rand_below(64))};
            default: w = {(mode == 1) ? 4'b0111 : 4'b0011, sr, base, 6'(rand_below(64))};
        endcase
        put_word(n, w);
        repeat (4)
            put_word(n, 16'h0000);
    end
    for (int r = 0; r < 8; r++)
        put_word(n, {4'b0111, 3'(r), 3'd7, 6'(r - 32)});   // top of memory
endtask

initial
begin
    clk = 1'b0;
    forever #20 clk = ~clk;
end

// instruction memory, 1 to 4 cycles per fetch
initial
begin
    logic rst_seen;
    i_resp  = 1'b0;
    i_rdata = '0;
    i_wait  = 0;
    forever
    begin
        @(posedge clk);
        rst_seen = reset;
        #2;
        if (rst_seen || i_resp)
        begin
            i_resp = 1'b0;
            i_wait = 0;
        end
        else if (i_read)
        begin
            if (i_wait == 0)
                i_wait = 1 + rand_below(4);
            i_wait--;
            if (i_wait == 0)
            begin
                i_resp  = 1'b1;
                i_rdata = imem[i_addr[10:1]];
            end
        end
        else
            i_wait = 0;
    end
end

// data memory, same latency range
initial
begin
    logic rst_seen;
    d_resp  = 1'b0;
    d_rdata = '0;
    d_wait  = 0;
    forever
    begin
        @(posedge clk);
        rst_seen = reset;
        #2;
        if (rst_seen || d_resp)
        begin
            d_resp = 1'b0;
            d_wait = 0;
        end
        else if (d_read || d_write)
        begin
            if (d_wait == 0)
                d_wait = 1 + rand_below(4);
            d_wait--;
            if (d_wait == 0)
            begin
                d_resp = 1'b1;
                if (d_write)
                begin
                    if (d_byte_enable[1])
                        dmem[d_addr[15:1]][15:8] = d_wdata[15:8];
                    if (d_byte_enable[0])
                        dmem[d_addr[15:1]][7:0] = d_wdata[7:0];
                end
                else
                    d_rdata = dmem[d_addr[15:1]];
            end
        end
        else
            d_wait = 0;
    end
end

initial
begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the CPU stopped storing results", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
end

initial
begin
    int words;
    int start_err;
    int start_fail;
    reset  = 1'b1;
    failed = 0;
    for (int t = 0; t < NUM_TESTS; t++)
    begin
        @(posedge clk);
        #2;
        reset = 1'b1;
        chk0.start_test();
        for (int i = 0; i < 1024; i++)
            imem[i] = '0;
        for (int i = 0; i < 32768; i++)
            dmem[i] = chk0.fill_word(i);
        gen_program(t, words);
        chk0.run_model(words);
        start_err  = chk0.errors;
        start_fail = dut0.asrt0.fail_count;
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        wait (chk0.writes_seen == chk0.writes_expected);
        repeat (20) @(posedge clk);     // catch stray stores
        if (chk0.errors != start_err || dut0.asrt0.fail_count != start_fail)
            failed++;
        $display("test %0d %s: %0d stores, %0d fetches checked, %0d errors, %0d assert fails",
                 t, test_name(t), chk0.writes_seen, chk0.fetches_seen,
                 chk0.errors - start_err, dut0.asrt0.fail_count - start_fail);
    end
    $display("%0d tests, %0d passed, %0d failed, %0d errors, %0d assert fails", NUM_TESTS,
             NUM_TESTS - failed, failed, chk0.errors, dut0.asrt0.fail_count);
    if (failed == 0)
        $display("TEST OK");
    else
        $display("TEST FAILED");
    $finish;
end

endmodule : tb_cpu

`default_nettype wire
